/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cache_mem_system
RTL_TOP   ?= cache_mem_system
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= all tests passed
VFLAGS    ?= --timing

SOURCES := $(wildcard design/*.sv) $(wildcard bench/*.sv) $(wildcard bench/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/cache_checks.svh */
`ifndef CACHE_CHECKS_SVH
`define CACHE_CHECKS_SVH

int    word_errs;
int    hit_errs;
int    stall_errs;
word_t model_mem    [32768];  // Flat word-addressed image of memory
tag_t  shadow_tag   [256];
logic  shadow_valid [256];

task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
        $display("ERR %s expected %h actual %h", name, exp, act);
        word_errs++;
    end
endtask

task automatic check_hit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        $display("ERR %s expected hit %b actual hit %b", name, exp, act);
        hit_errs++;
    end
endtask

task automatic check_stall(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        $display("ERR %s expected stall %b actual stall %b", name, exp, act);
        stall_errs++;
    end
endtask

// Power-up content is the inverted word address
function automatic void model_reset();
    for (int i = 0; i < 32768; i++) begin
        model_mem[i] = ~word_t'(i);
    end
    for (int j = 0; j < 256; j++) begin
        shadow_tag[j]   = '0;
        shadow_valid[j] = 1'b0;
    end
endfunction

function automatic word_t model_read(input addr_t addr);
    return model_mem[addr[15:1]];
endfunction

function automatic logic model_hit(input addr_t addr);
    return shadow_valid[addr[10:3]] && (shadow_tag[addr[10:3]] == addr[15:11]);
endfunction

// Every access leaves its line resident
function automatic void model_update(input addr_t addr, input logic is_wr, input word_t wdata);
    if (is_wr) begin
        model_mem[addr[15:1]] = wdata;
    end
    shadow_tag[addr[10:3]]   = addr[15:11];
    shadow_valid[addr[10:3]] = 1'b1;
endfunction

`endif

/* bench/tb_cache_mem_system.sv */
`timescale 1ns/1ns
module tb_cache_mem_system
    import cache_pkg::*;
();

    localparam int BANK_LATENCY = 2;
    localparam int N_DIRECTED   = 16;
    localparam int N_RANDOM     = 400;
    localparam int CYCLE_LIMIT  = (N_DIRECTED + N_RANDOM) * 60 + 100;

    logic      clk;
    logic      rst_n;
    proc_req_t req;
    word_t     rdata;
    logic      done;
    logic      cache_hit;
    logic      stall;
    int        cycle_cnt;

    tag_t   tag_set [4] = '{5'h00, 5'h02, 5'h09, 5'h1f};  // Random test conflict set
    index_t idx_set [4] = '{8'h05, 8'h30, 8'h81, 8'hff};

    `include "cache_checks.svh"

    cache_mem_system #(
        .BANK_LATENCY (BANK_LATENCY)
    ) dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .rdata     (rdata),
        .done      (done),
        .cache_hit (cache_hit),
        .stall     (stall)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic addr_t make_addr(input tag_t tag, input index_t idx, input word_sel_t w);
        return {tag, idx, w, 1'b0};
    endfunction

    task automatic print_counts();
        $display("Errors: data %0d, hit %0d, stall %0d", word_errs, hit_errs, stall_errs);
    endtask

    // Cycle limit guards against a request that never completes
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles, a request never completed", cycle_cnt);
            print_counts();
            $display("tests failed");
            $finish;
        end
    end

    // Held until done, dropped on the following edge
    task automatic run_req(input string name, input addr_t addr, input logic is_wr,
                           input word_t wdata, input logic exp_stall,
                           output word_t rd_word, output logic hit_flag);
        @(posedge clk);
        req.addr  <= addr;
        req.wdata <= wdata;
        req.rd    <= ~is_wr;
        req.wr    <= is_wr;
        do begin
            @(negedge clk);  // Outputs settled mid-cycle
            if (done !== 1'b1) begin
                check_stall(name, exp_stall, stall);  // Miss stalls until done
            end
        end while (done !== 1'b1);
        rd_word  = rdata;
        hit_flag = cache_hit;
        @(posedge clk);
        req <= '0;
    endtask

    task automatic access_and_check(input string name, input addr_t addr, input logic is_wr,
                                    input word_t wdata);
        word_t exp_word;
        logic  exp_hit;
        logic  exp_miss;
        word_t got_word;
        logic  got_hit;
        exp_word = model_read(addr);
        exp_hit  = is_wr ? 1'b0 : model_hit(addr);  // Writes never flag a hit
        exp_miss = !model_hit(addr);
        run_req(name, addr, is_wr, wdata, exp_miss, got_word, got_hit);
        if (!is_wr) begin
            check_word(name, exp_word, got_word);
        end
        check_hit(name, exp_hit, got_hit);
        model_update(addr, is_wr, wdata);
    endtask

    initial begin
        tag_t      r_tag;
        index_t    r_idx;
        word_sel_t r_word;
        logic      r_wr;
        word_t     r_data;
        rst_n      = 1'b0;
        req        = '0;
        cycle_cnt  = 0;
        word_errs  = 0;
        hit_errs   = 0;
        stall_errs = 0;
        void'($urandom(22470));
        model_reset();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        // Cold miss then hit
        access_and_check("cold_miss", make_addr(5'h03, 8'h10, 2'd2), 1'b0, '0);
        access_and_check("cold_rehit", make_addr(5'h03, 8'h10, 2'd2), 1'b0, '0);

        // Write then read back
        access_and_check("wr_first", make_addr(5'h04, 8'h11, 2'd1), 1'b1, 16'hbeef);
        access_and_check("wr_readback", make_addr(5'h04, 8'h11, 2'd1), 1'b0, '0);

        // Dirty line evicted by a conflicting tag
        access_and_check("evict_wr", make_addr(5'h01, 8'h20, 2'd1), 1'b1, 16'h1234);
        access_and_check("evict_other", make_addr(5'h06, 8'h20, 2'd1), 1'b0, '0);
        access_and_check("evict_back", make_addr(5'h01, 8'h20, 2'd1), 1'b0, '0);

        // Whole line dirty, written back across all four banks
        for (int w = 0; w < 4; w++) begin
            access_and_check("line_wr", make_addr(5'h02, 8'h30, word_sel_t'(w)), 1'b1,
                             word_t'(16'hc000 + w));
        end
        access_and_check("line_conflict", make_addr(5'h09, 8'h30, 2'd0), 1'b0, '0);
        for (int w = 0; w < 4; w++) begin
            access_and_check("line_rd", make_addr(5'h02, 8'h30, word_sel_t'(w)), 1'b0, '0);
        end

        for (int n = 0; n < N_RANDOM; n++) begin
            r_tag  = tag_set[$urandom_range(3)];
            r_idx  = idx_set[$urandom_range(3)];
            r_word = word_sel_t'($urandom_range(3));
            r_wr   = 1'($urandom_range(1));
            r_data = word_t'($urandom);
            access_and_check(r_wr ? "rand_wr" : "rand_rd", make_addr(r_tag, r_idx, r_word),
                             r_wr, r_data);
        end

        repeat (2) @(posedge clk);
        print_counts();
        if (word_errs + hit_errs + stall_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* design/banked_memory.sv */
`timescale 1ns/1ns
module banked_memory
    import cache_pkg::*;
#(
    parameter int BANK_LATENCY = 2
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [14:0] mem_addr,
    input  word_t       mem_wdata,
    input  logic        mem_rd,
    input  logic        mem_wr,
    output word_t       mem_rdata,
    output logic [3:0]  bank_busy,
    output logic        mem_stall
);

    localparam int DEPTH = 2 ** 15;
    localparam int BANKS = 4;
    localparam int CNT_W = $clog2(BANK_LATENCY + 1);

    word_t            mem_array [DEPTH];
    word_t            rd_pipe   [BANK_LATENCY];
    logic [CNT_W-1:0] busy_cnt  [BANKS];
    logic [1:0]       bank_sel;
    logic             accept;

    assign bank_sel  = mem_addr[1:0];              // Low word bits pick the bank
    assign mem_stall = bank_busy[bank_sel];
    assign accept    = (mem_rd | mem_wr) & ~mem_stall;
    assign mem_rdata = rd_pipe[BANK_LATENCY-1];

    always_comb begin
        for (int b = 0; b < BANKS; b++) begin
            bank_busy[b] = (busy_cnt[b] != '0);
        end
    end

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem_array[i] = mem_init_word(15'(i));
        end
    end

    // Per-bank recovery timers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int b = 0; b < BANKS; b++) begin
                busy_cnt[b] <= '0;
            end
        end else begin
            for (int b = 0; b < BANKS; b++) begin
                if (accept && bank_sel == 2'(b)) begin
                    busy_cnt[b] <= CNT_W'(BANK_LATENCY);
                end else if (busy_cnt[b] != '0) begin
                    busy_cnt[b] <= busy_cnt[b] - 1'b1;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (accept && mem_wr) begin
            mem_array[mem_addr] <= mem_wdata;
        end
    end

    // Read data pipe, the last stage lines up with BANK_LATENCY
    always_ff @(posedge clk) begin
        rd_pipe[0] <= mem_array[mem_addr];
        for (int i = 1; i < BANK_LATENCY; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
    end

endmodule

/* design/cache_ctrl.sv */
`timescale 1ns/1ns
module cache_ctrl
    import cache_pkg::*;
#(
    parameter int BANK_LATENCY = 2
) (
    input  logic         clk,
    input  logic         rst_n,
    input  proc_req_t    req,
    output line_access_t line_acc,
    input  line_status_t line_stat,
    output logic [14:0]  mem_addr,
    output word_t        mem_wdata,
    output logic         mem_rd,
    output logic         mem_wr,
    input  word_t        mem_rdata,
    input  logic         mem_stall,
    output word_t        rdata,
    output logic         done,
    output logic         cache_hit,
    output logic         stall
);

    typedef enum logic [2:0] {
        S_IDLE,        // Compare tags, read hits finish here
        S_WR_DONE,     // Write complete
        S_WB,          // Dirty victim to memory
        S_FILL_ISSUE,  // One read per bank
        S_FILL_DRAIN,  // Wait for the last return
        S_FINISH       // Retry the access on the new line
    } state_t;

    // Word number riding alongside an outstanding fill read
    typedef struct packed {
        logic      vld;
        word_sel_t sel;
    } fill_tag_t;

    localparam word_sel_t LAST_WORD = word_sel_t'(LINE_WORDS - 1);

    state_t    state;
    state_t    nxt_state;
    word_sel_t wcnt;
    logic      wcnt_inc;
    logic      fill_accept;
    fill_tag_t [BANK_LATENCY-1:0] ret_pipe;
    fill_tag_t ret_out;

    tag_t      req_tag;
    index_t    req_index;
    word_sel_t req_word;
    logic      access;
    logic      hit;

    assign req_tag   = addr_tag(req.addr);
    assign req_index = addr_index(req.addr);
    assign req_word  = addr_word(req.addr);
    assign access    = req.rd | req.wr;
    assign hit       = line_stat.valid && (line_stat.tag == req_tag);
    assign rdata     = line_stat.rdata;  // Word from the addressed line
    assign ret_out   = ret_pipe[BANK_LATENCY-1];

    always_comb begin
        line_acc           = '0;
        line_acc.index     = req_index;
        line_acc.word_sel  = req_word;
        line_acc.tag       = req_tag;
        line_acc.wdata     = req.wdata;
        line_acc.dirty_val = 1'b1;

        mem_addr    = {req_tag, req_index, wcnt};
        mem_wdata   = line_stat.rdata;
        mem_rd      = 1'b0;
        mem_wr      = 1'b0;
        done        = 1'b0;
        cache_hit   = 1'b0;
        stall       = 1'b0;
        wcnt_inc    = 1'b0;
        fill_accept = 1'b0;
        nxt_state   = state;

        // Returning fill word goes straight into the store
        if (ret_out.vld) begin
            line_acc.word_sel  = ret_out.sel;
            line_acc.wdata     = mem_rdata;
            line_acc.set_tag   = 1'b1;
            line_acc.dirty_val = 1'b0;
        end

        case (state)
            S_IDLE: begin
                if (access) begin
                    if (hit && req.rd) begin
                        done      = 1'b1;
                        cache_hit = 1'b1;
                    end else if (hit) begin
                        line_acc.we = 1'b1;  // Write hit marks line dirty
                        nxt_state   = S_WR_DONE;
                    end else begin
                        stall     = 1'b1;
                        nxt_state = (line_stat.valid && line_stat.dirty) ? S_WB : S_FILL_ISSUE;
                    end
                end
            end

            S_WR_DONE: begin
                done      = 1'b1;
                nxt_state = S_IDLE;
            end

            S_WB: begin
                stall             = 1'b1;
                line_acc.word_sel = wcnt;
                mem_addr          = {line_stat.tag, req_index, wcnt};  // Victim address
                mem_wr            = 1'b1;
                if (!mem_stall) begin
                    wcnt_inc = 1'b1;
                    if (wcnt == LAST_WORD) begin
                        nxt_state = S_FILL_ISSUE;
                    end
                end
            end

            S_FILL_ISSUE: begin
                stall  = 1'b1;
                mem_rd = 1'b1;
                if (!mem_stall) begin
                    fill_accept = 1'b1;
                    wcnt_inc    = 1'b1;
                    if (wcnt == LAST_WORD) begin
                        nxt_state = S_FILL_DRAIN;
                    end
                end
            end

            S_FILL_DRAIN: begin
                stall = 1'b1;
                if (ret_out.vld && ret_out.sel == LAST_WORD) begin
                    nxt_state = S_FINISH;
                end
            end

            S_FINISH: begin
                if (req.rd) begin
                    done      = 1'b1;  // Read data now from the filled line
                    nxt_state = S_IDLE;
                end else begin
                    stall       = 1'b1;
                    line_acc.we = 1'b1;
                    nxt_state   = S_WR_DONE;
                end
            end

            default: begin
                nxt_state = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= S_IDLE;
            wcnt  <= '0;
        end else begin
            state <= nxt_state;
            if (wcnt_inc) begin
                wcnt <= wcnt + 1'b1;  // Wraps to zero after the last word
            end
        end
    end

    // Tags each accepted fill read until its data comes back
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ret_pipe <= '0;
        end else begin
            ret_pipe[0].vld <= fill_accept;
            ret_pipe[0].sel <= wcnt;
            for (int i = 1; i < BANK_LATENCY; i++) begin
                ret_pipe[i] <= ret_pipe[i-1];
            end
        end
    end

endmodule

/* design/cache_line_store.sv */
`timescale 1ns/1ns
module cache_line_store
    import cache_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  line_access_t line_acc,
    output line_status_t line_stat
);

    localparam int LINES = 2 ** $bits(index_t);
    localparam int WORDS = LINES * LINE_WORDS;

    tag_t             tag_arr  [LINES];
    word_t            data_arr [WORDS];
    logic [LINES-1:0] valid_bits;
    logic [LINES-1:0] dirty_bits;

    logic             line_wr;
    logic [$clog2(WORDS)-1:0] word_addr;

    assign line_wr   = line_acc.we | line_acc.set_tag;
    assign word_addr = {line_acc.index, line_acc.word_sel};  // Line-major word layout

    // Status of the addressed line, read without a clock
    always_comb begin
        line_stat.tag   = tag_arr[line_acc.index];
        line_stat.valid = valid_bits[line_acc.index];
        line_stat.dirty = dirty_bits[line_acc.index];
        line_stat.rdata = data_arr[word_addr];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (line_wr) begin
            valid_bits[line_acc.index] <= 1'b1;
            dirty_bits[line_acc.index] <= line_acc.dirty_val;
        end
    end

    // Tag and data follow any line write
    always_ff @(posedge clk) begin
        if (line_wr) begin
            tag_arr[line_acc.index] <= line_acc.tag;
            data_arr[word_addr]     <= line_acc.wdata;
        end
    end

endmodule

/* design/cache_mem_system.sv */
`timescale 1ns/1ns
module cache_mem_system
    import cache_pkg::*;
#(
    parameter int BANK_LATENCY = 2
) (
    input  logic      clk,
    input  logic      rst_n,
    input  proc_req_t req,
    output word_t     rdata,
    output logic      done,
    output logic      cache_hit,
    output logic      stall
);

    line_access_t line_acc;
    line_status_t line_stat;
    logic [14:0]  mem_addr;   // Word address
    word_t        mem_wdata;
    word_t        mem_rdata;
    logic         mem_rd;
    logic         mem_wr;
    logic         mem_stall;

    cache_ctrl #(
        .BANK_LATENCY (BANK_LATENCY)
    ) ctrl0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .line_acc  (line_acc),
        .line_stat (line_stat),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rd    (mem_rd),
        .mem_wr    (mem_wr),
        .mem_rdata (mem_rdata),
        .mem_stall (mem_stall),
        .rdata     (rdata),
        .done      (done),
        .cache_hit (cache_hit),
        .stall     (stall)
    );

    cache_line_store store0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .line_acc  (line_acc),
        .line_stat (line_stat)
    );

    banked_memory #(
        .BANK_LATENCY (BANK_LATENCY)
    ) mem0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rd    (mem_rd),
        .mem_wr    (mem_wr),
        .mem_rdata (mem_rdata),
        .bank_busy (),            // Only seen through mem_stall
        .mem_stall (mem_stall)
    );

endmodule

/* design/cache_pkg.sv */
package cache_pkg;

    typedef logic [15:0] word_t;
    typedef logic [4:0]  tag_t;
    typedef logic [7:0]  index_t;
    typedef logic [1:0]  word_sel_t;
    typedef logic [15:0] addr_t;

    localparam int LINE_WORDS = 4;  // Words per cache line

    typedef struct packed {
        addr_t addr;
        word_t wdata;
        logic  rd;
        logic  wr;
    } proc_req_t;

    typedef struct packed {
        index_t    index;
        word_sel_t word_sel;
        tag_t      tag;
        word_t     wdata;
        logic      we;         // Data word write
        logic      set_tag;    // Fill write, also sets valid
        logic      dirty_val;  // Dirty bit written with we or set_tag
    } line_access_t;

    typedef struct packed {
        tag_t  tag;
        logic  valid;
        logic  dirty;
        word_t rdata;
    } line_status_t;

    // Byte address split: tag 15:11, index 10:3, word 2:1
    function automatic tag_t addr_tag(input addr_t addr);
        return addr[15:11];
    endfunction

    function automatic index_t addr_index(input addr_t addr);
        return addr[10:3];
    endfunction

    function automatic word_sel_t addr_word(input addr_t addr);
        return addr[2:1];
    endfunction

    function automatic word_t mem_init_word(input logic [14:0] waddr);
        return ~{1'b0, waddr};  // Inverted word address
    endfunction

endpackage

/* tb.f */
+incdir+bench
design/cache_pkg.sv
design/cache_line_store.sv
design/banked_memory.sv
design/cache_ctrl.sv
design/cache_mem_system.sv
bench/tb_cache_mem_system.sv
